/* Makefile */
# Verilator build and run for the single-cycle RV32I core

VERILATOR ?= verilator
TOP       ?= riscv_core_tb
SEED      ?= 32\'hb6a6c13b
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= verilog.f

BIN    := $(OBJ_DIR)/V$(TOP)
VFLAGS ?= --binary --assert --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

# always rebuilds so that a new SEED takes effect
compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) && echo "pass message found in $(LOG)" || \
		(echo "pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/riscv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_alu import riscv_pkg::*; (
    input  wire word_t       op_a_i,
    input  wire word_t       op_b_i,
    riscv_ctrl_if.alu        ctrl,
    output word_t            result_o,
    output logic             flag_o               // branch condition
);

    logic [4:0] shamt;
    logic       lt_s;                             // signed a < b
    logic       lt_u;                             // unsigned a < b

    assign shamt = op_b_i[4:0];                   // only low 5 bits shift
    assign lt_s  = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u  = op_a_i < op_b_i;

    always_comb begin
        result_o = '0;
        flag_o   = 1'b0;
        case (ctrl.alu_op)
            ADD:  result_o = op_a_i + op_b_i;
            SUB:  result_o = op_a_i - op_b_i;
            SLL:  result_o = op_a_i << shamt;
            SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            XOR:  result_o = op_a_i ^ op_b_i;
            SRL:  result_o = op_a_i >> shamt;
            SRA:  result_o = word_t'($signed(op_a_i) >>> shamt);
            OR:   result_o = op_a_i | op_b_i;
            AND:  result_o = op_a_i & op_b_i;
            // compare group, result stays zero
            EQ:   flag_o = (op_a_i == op_b_i);
            NE:   flag_o = (op_a_i != op_b_i);
            LT:   flag_o = lt_s;
            GE:   flag_o = !lt_s;
            LTU:  flag_o = lt_u;
            GEU:  flag_o = !lt_u;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/riscv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_core import riscv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  wire              CLK,
    input  wire              RESET,
    // instruction fetch
    output word_t            imem_addr_o,
    input  wire word_t       imem_data_i,
    // data memory, combinational within the cycle
    output logic             dmem_req_o,
    output logic             dmem_we_o,
    output word_t            dmem_addr_o,
    output word_t            dmem_wdata_o,
    input  wire word_t       dmem_rdata_i,
    output logic             illegal_instr_o
);

    word_t pc;
    word_t rs1_data;
    word_t rs2_data;
    word_t op_a;
    word_t op_b;
    word_t alu_result;
    logic  alu_flag;
    word_t rf_wd;

    riscv_ctrl_if ctrl_if ();

    //////////////////////////////////////////////////
    // control and datapath
    //////////////////////////////////////////////////
    riscv_decoder u_decoder (
        .CLK             (CLK),
        .RESET           (RESET),
        .instr_i         (imem_data_i),
        .ctrl            (ctrl_if.ctrl),
        .illegal_instr_o (illegal_instr_o)
    );

    riscv_regfile u_regfile (
        .CLK   (CLK),
        .RESET (RESET),
        .ra1_i (imem_data_i[19:15]),              // rs1
        .ra2_i (imem_data_i[24:20]),              // rs2
        .wa_i  (imem_data_i[11:7]),               // rd
        .wd_i  (rf_wd),
        .we_i  (ctrl_if.rf_we),
        .rd1_o (rs1_data),
        .rd2_o (rs2_data)
    );

    riscv_operand_sel u_operand_sel (
        .instr_i    (imem_data_i),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ctrl       (ctrl_if.operand),
        .op_a_o     (op_a),
        .op_b_o     (op_b)
    );

    riscv_alu u_alu (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .ctrl     (ctrl_if.alu),
        .result_o (alu_result),
        .flag_o   (alu_flag)
    );

    riscv_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .CLK          (CLK),
        .RESET        (RESET),
        .instr_i      (imem_data_i),
        .alu_result_i (alu_result),
        .alu_flag_i   (alu_flag),
        .ctrl         (ctrl_if.fetch),
        .pc_o         (pc)
    );

    // write-back: load data, jalr link, or alu result
    always_comb begin
        if (ctrl_if.wb_sel == MEM)
            rf_wd = dmem_rdata_i;
        else if (ctrl_if.jalr)
            rf_wd = pc + XLEN'(4);                // alu is busy with the target
        else
            rf_wd = alu_result;
    end

    assign imem_addr_o  = pc;
    assign dmem_req_o   = ctrl_if.mem_req;
    assign dmem_we_o    = ctrl_if.mem_we;
    assign dmem_addr_o  = alu_result;             // rs1 + imm_I / imm_S
    assign dmem_wdata_o = rs2_data;

endmodule

`default_nettype wire

/* hw/riscv_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

// decoded control bundle, one decoder drives, datapath blocks listen
interface riscv_ctrl_if import riscv_pkg::*; ();

    alu_op_e   alu_op;                            // alu operation
    op_a_sel_e op_a_sel;                          // operand a mux
    op_b_sel_e op_b_sel;                          // operand b mux
    logic      rf_we;                             // register write enable
    wb_sel_e   wb_sel;                            // write-back source
    logic      mem_req;                           // data memory access
    logic      mem_we;                            // 1 = store
    logic      branch;                            // conditional branch
    logic      jal;
    logic      jalr;

    modport ctrl (
        output alu_op, op_a_sel, op_b_sel, rf_we, wb_sel,
        output mem_req, mem_we, branch, jal, jalr
    );

    modport operand (input op_a_sel, op_b_sel);
    modport alu     (input alu_op);
    modport fetch   (input branch, jal, jalr);
    // jalr here selects the link value pc + 4 on write-back
    modport core    (input rf_we, wb_sel, mem_req, mem_we, jalr);

endinterface

`default_nettype wire

/* hw/riscv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_decoder import riscv_pkg::*; (
    input  wire              CLK,
    input  wire              RESET,
    input  wire word_t       instr_i,             // fetched instruction
    riscv_ctrl_if.ctrl       ctrl,                // decoded control bundle
    output logic             illegal_instr_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       illegal;                          // raw flag, before reset gating

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    //////////////////////////////////////////////////
    // main decode
    //////////////////////////////////////////////////
    always_comb begin
        // defaults: add rs1 + rs2, nothing written
        ctrl.alu_op   = ADD;
        ctrl.op_a_sel = RS1;
        ctrl.op_b_sel = RS2;
        ctrl.rf_we    = 1'b0;
        ctrl.wb_sel   = ALU;
        ctrl.mem_req  = 1'b0;
        ctrl.mem_we   = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.jal      = 1'b0;
        ctrl.jalr     = 1'b0;
        illegal       = 1'b0;

        case (opcode)
            OP, OP_IMM: begin
                ctrl.rf_we    = 1'b1;
                ctrl.op_b_sel = (opcode == OP) ? RS2 : IMM_I;
                case (funct3)
                    3'b000: ctrl.alu_op = ADD;
                    3'b001: ctrl.alu_op = SLL;
                    3'b010: ctrl.alu_op = SLT;
                    3'b011: ctrl.alu_op = SLTU;
                    3'b100: ctrl.alu_op = XOR;
                    3'b101: ctrl.alu_op = SRL;
                    3'b110: ctrl.alu_op = OR;
                    default: ctrl.alu_op = AND;
                endcase
                // funct7 matters for every R-type and for the imm shifts
                if (opcode == OP || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct7 == 7'b0100000) begin
                        if (funct3 == 3'b101)
                            ctrl.alu_op = SRA;
                        else if (funct3 == 3'b000 && opcode == OP)
                            ctrl.alu_op = SUB;
                        else
                            illegal = 1'b1;   // only sub, sra, srai take it
                    end else if (funct7 != 7'b0000000) begin
                        illegal = 1'b1;
                    end
                end
            end
            LOAD: begin
                ctrl.op_b_sel = IMM_I;            // addr = rs1 + imm_I
                ctrl.mem_req  = 1'b1;
                ctrl.rf_we    = 1'b1;
                ctrl.wb_sel   = MEM;
                illegal       = (funct3 != 3'b010);   // word access only
            end
            STORE: begin
                ctrl.op_b_sel = IMM_S;            // addr = rs1 + imm_S
                ctrl.mem_req  = 1'b1;
                ctrl.mem_we   = 1'b1;
                illegal       = (funct3 != 3'b010);
            end
            BRANCH: begin
                ctrl.branch = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = EQ;
                    3'b001: ctrl.alu_op = NE;
                    3'b100: ctrl.alu_op = LT;
                    3'b101: ctrl.alu_op = GE;
                    3'b110: ctrl.alu_op = LTU;
                    3'b111: ctrl.alu_op = GEU;
                    default: illegal = 1'b1;      // 010, 011
                endcase
            end
            JAL: begin
                ctrl.jal      = 1'b1;
                ctrl.rf_we    = 1'b1;
                ctrl.op_a_sel = PC;               // link = pc + 4 through alu
                ctrl.op_b_sel = FOUR;
            end
            JALR: begin
                ctrl.jalr     = 1'b1;
                ctrl.rf_we    = 1'b1;
                ctrl.op_b_sel = IMM_I;            // target = rs1 + imm_I
            end
            LUI: begin
                ctrl.rf_we    = 1'b1;
                ctrl.op_a_sel = ZERO;
                ctrl.op_b_sel = IMM_U;
            end
            AUIPC: begin
                ctrl.rf_we    = 1'b1;
                ctrl.op_a_sel = PC;
                ctrl.op_b_sel = IMM_U;
            end
            MISC_MEM, SYSTEM: ;                   // fence / ecall / ebreak as nop
            default: illegal = 1'b1;              // unknown opcode
        endcase

        if (instr_i[1:0] != 2'b11)
            illegal = 1'b1;                       // compressed space not supported

        // kill side effects, pc still moves on by 4
        if (illegal || RESET) begin
            ctrl.rf_we   = 1'b0;
            ctrl.mem_req = 1'b0;
            ctrl.mem_we  = 1'b0;
            ctrl.branch  = 1'b0;
            ctrl.jal     = 1'b0;
            ctrl.jalr    = 1'b0;
        end
        illegal_instr_o = illegal && !RESET;
    end

    // a store never goes out without a request
    a_we_needs_req : assert property (@(posedge CLK) disable iff (RESET)
        ctrl.mem_we |-> ctrl.mem_req);

endmodule

`default_nettype wire

/* hw/riscv_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_fetch import riscv_pkg::*; #(
    parameter word_t RESET_PC = '0                // first fetch address
) (
    input  wire              CLK,
    input  wire              RESET,
    input  wire word_t       instr_i,
    input  wire word_t       alu_result_i,        // jalr target
    input  wire              alu_flag_i,          // branch taken
    riscv_ctrl_if.fetch      ctrl,
    output word_t            pc_o
);

    word_t pc_q;
    word_t pc_next;
    word_t imm_b;
    word_t imm_j;

    // B: imm[12|10:5] ... imm[4:1|11], bit 0 always zero
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    // J: imm[20|10:1|11|19:12]
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        if (ctrl.jalr)
            pc_next = {alu_result_i[XLEN-1:1], 1'b0};   // rs1 + imm_I, bit 0 cleared
        else if (ctrl.jal)
            pc_next = pc_q + imm_j;
        else if (ctrl.branch && alu_flag_i)
            pc_next = pc_q + imm_b;
        else
            pc_next = pc_q + XLEN'(4);                  // also illegal words
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            pc_q <= RESET_PC;
        else
            pc_q <= pc_next;
    end

    assign pc_o = pc_q;

    // a jump into a misaligned target shows up one cycle later
    a_pc_aligned : assert property (@(posedge CLK) disable iff (RESET)
        1'b1 |=> (pc_o[1:0] == 2'b00));

endmodule

`default_nettype wire

/* hw/riscv_operand_sel.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_operand_sel import riscv_pkg::*; (
    input  wire word_t       instr_i,
    input  wire word_t       pc_i,                // pc of this instruction
    input  wire word_t       rs1_data_i,
    input  wire word_t       rs2_data_i,
    riscv_ctrl_if.operand    ctrl,
    output word_t            op_a_o,
    output word_t            op_b_o
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_u;

    //////////////////////////////////////////////////
    // immediates
    //////////////////////////////////////////////////
    // I: sign from bit 31, imm[11:0] = instr[31:20]
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    // S: imm[11:5] upper, imm[4:0] sits in the rd field
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u = {instr_i[31:12], 12'b0};    // lui / auipc

    //////////////////////////////////////////////////
    // operand muxes
    //////////////////////////////////////////////////
    always_comb begin
        case (ctrl.op_a_sel)
            RS1:     op_a_o = rs1_data_i;
            PC:      op_a_o = pc_i;           // auipc, jal link
            default: op_a_o = '0;             // ZERO for lui
        endcase
    end

    always_comb begin
        case (ctrl.op_b_sel)
            RS2:     op_b_o = rs2_data_i;
            IMM_I:   op_b_o = imm_i;
            IMM_U:   op_b_o = imm_u;
            IMM_S:   op_b_o = imm_s;
            FOUR:    op_b_o = XLEN'(4);
            default: op_b_o = '0;
        endcase
    end

    // decoder must only hand out the five defined sources
    always_comb begin
        a_op_b_legal : assert (ctrl.op_b_sel inside {RS2, IMM_I, IMM_U, IMM_S, FOUR});
    end

endmodule

`default_nettype wire

/* hw/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    //////////////////////////////////////////////////
    // widths and word types
    //////////////////////////////////////////////////
    localparam int XLEN       = 32;               // data / address / instr width
    localparam int REG_ADDR_W = 5;                // x0..x31

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //////////////////////////////////////////////////
    // major opcodes, instr[6:0]
    //////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OP       = 7'b0110011,                    // R-type alu
        OP_IMM   = 7'b0010011,                    // I-type alu
        LOAD     = 7'b0000011,                    // lw only
        STORE    = 7'b0100011,                    // sw only
        BRANCH   = 7'b1100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        MISC_MEM = 7'b0001111,                    // fence, nop here
        SYSTEM   = 7'b1110011                     // ecall / ebreak, nop here
    } opcode_e;

    // alu operations, compare group sets the branch flag
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        EQ   = 4'd10,                             // beq
        NE   = 4'd11,                             // bne
        LT   = 4'd12,                             // blt
        GE   = 4'd13,                             // bge
        LTU  = 4'd14,                             // bltu
        GEU  = 4'd15                              // bgeu
    } alu_op_e;

    // operand a source
    typedef enum logic [1:0] {
        RS1  = 2'd0,
        PC   = 2'd1,
        ZERO = 2'd2
    } op_a_sel_e;

    // operand b source, 5..7 unused
    typedef enum logic [2:0] {
        RS2   = 3'd0,
        IMM_I = 3'd1,
        IMM_U = 3'd2,
        IMM_S = 3'd3,
        FOUR  = 3'd4                              // link value pc + 4
    } op_b_sel_e;

    // register write-back source
    typedef enum logic {
        ALU = 1'b0,
        MEM = 1'b1
    } wb_sel_e;

endpackage

`default_nettype wire

/* hw/riscv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_regfile import riscv_pkg::*; (
    input  wire              CLK,
    input  wire              RESET,
    input  wire reg_addr_t   ra1_i,               // rs1 index
    input  wire reg_addr_t   ra2_i,               // rs2 index
    input  wire reg_addr_t   wa_i,                // rd index
    input  wire word_t       wd_i,
    input  wire              we_i,
    output word_t            rd1_o,
    output word_t            rd2_o
);

    word_t regs [32];                             // x0 cleared by reset, never written

    // write at the edge, x0 writes dropped
    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // combinational read ports
    assign rd1_o = regs[ra1_i];
    assign rd2_o = regs[ra2_i];

    // x0 stays zero even right after a write aimed at it
    a_x0_zero : assert property (@(posedge CLK) disable iff (RESET)
        ((ra1_i == '0) |-> (rd1_o == '0)) and ((ra2_i == '0) |-> (rd2_o == '0)));

endmodule

`default_nettype wire

/* include/riscv_tb_checks.svh */
`ifndef RISCV_TB_CHECKS_SVH
`define RISCV_TB_CHECKS_SVH

//////////////////////////////////////////////////
// counters and per-test bookkeeping
//////////////////////////////////////////////////
int n_pass   = 0;                                 // tests without a wrong value
int n_fail   = 0;
int row_errs = 0;                                 // errors of the test in progress

// compare one word output
task automatic check_word(input string name, input string what,
                          input word_t exp, input word_t act);
    if (act !== exp) begin
        $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, act);
        row_errs++;
    end
endtask

// compare one single-bit output
task automatic check_flag(input string name, input string what,
                          input logic exp, input logic act);
    if (act !== exp) begin
        $display("Mismatch %s %s: expected %b, actual %b", name, what, exp, act);
        row_errs++;
    end
endtask

// one line per finished test
task automatic test_done(input string name);
    if (row_errs == 0) begin
        n_pass++;
        $display("ok      %s", name);
    end else begin
        n_fail++;
        $display("failed  %s (%0d wrong values)", name, row_errs);
    end
    row_errs = 0;
endtask

//////////////////////////////////////////////////
// random operands
//////////////////////////////////////////////////
// mix of small, negative and full-range words
function automatic word_t rand_operand();
    case ($urandom_range(2, 0))
        0:       return word_t'($urandom_range(31, 0));  // small, good shift counts
        1:       return {1'b1, 31'($urandom)};           // negative
        default: return $urandom;
    endcase
endfunction

// word-aligned target for jalr with bit 0 set, so the clear is visible
function automatic word_t rand_jalr_base();
    return {30'($urandom), 2'b01};
endfunction

`endif

/* test/riscv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_core_tb import riscv_pkg::*; #(
    parameter int unsigned SEED = 32'hb6a6_c13b
) ();

    localparam word_t RESET_PC = 32'h0000_0200;
    localparam word_t NOP      = 32'h0000_0013;   // addi x0, x0, 0
    localparam int    PC_WAIT  = 8;               // cycles allowed for a fetch address

    typedef struct {
        string name;
        word_t instr;
        word_t rdata;                             // dmem_rdata_i in this cycle
        word_t next_pc;
        logic  req;
        logic  we;
        word_t addr;                              // checked only with req
        word_t wdata;                             // checked only with we
        logic  ill;
    } row_t;

    logic  CLK;
    logic  RESET;
    word_t imem_data;
    word_t dmem_rdata;
    word_t imem_addr;
    logic  dmem_req;
    logic  dmem_we;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  illegal;

    row_t  rows [$];                              // stimulus table
    word_t xr [32];                               // register model
    word_t mpc;                                   // pc model while the table is built
    word_t reset_words [3];                       // words decoded while RESET holds
    bit    pc_ok;                                 // fetch address came up in time

    `include "riscv_tb_checks.svh"

    riscv_core #(
        .RESET_PC (RESET_PC)
    ) dut (
        .CLK             (CLK),
        .RESET           (RESET),
        .imem_addr_o     (imem_addr),
        .imem_data_i     (imem_data),
        .dmem_req_o      (dmem_req),
        .dmem_we_o       (dmem_we),
        .dmem_addr_o     (dmem_addr),
        .dmem_wdata_o    (dmem_wdata),
        .dmem_rdata_i    (dmem_rdata),
        .illegal_instr_o (illegal)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;                   // 20 ns period
    end

    //////////////////////////////////////////////////
    // ISA reference rules
    //////////////////////////////////////////////////
    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t alu_rule(input string mn, input word_t a, input word_t b);
        case (mn)
            "add", "addi":   return a + b;
            "sub":           return a - b;
            "sll", "slli":   return a << b[4:0];
            "slt", "slti":   return {31'b0, $signed(a) < $signed(b)};
            "sltu", "sltiu": return {31'b0, a < b};
            "xor", "xori":   return a ^ b;
            "srl", "srli":   return a >> b[4:0];
            "sra", "srai":   return word_t'($signed(a) >>> b[4:0]);
            "or", "ori":     return a | b;
            default:         return a & b;        // and, andi
        endcase
    endfunction

    function automatic logic branch_taken(input string mn, input word_t a, input word_t b);
        case (mn)
            "beq":   return a == b;
            "bne":   return a != b;
            "blt":   return $signed(a) < $signed(b);
            "bge":   return $signed(a) >= $signed(b);
            "bltu":  return a < b;
            default: return a >= b;               // bgeu
        endcase
    endfunction

    //////////////////////////////////////////////////
    // table builders
    //////////////////////////////////////////////////
    task automatic add_row(input string name, input word_t instr, input word_t rdata,
                           input word_t next_pc, input logic req, input logic we,
                           input word_t addr, input word_t wdata, input logic ill);
        rows.push_back('{name, instr, rdata, next_pc, req, we, addr, wdata, ill});
        mpc = next_pc;
    endtask

    task automatic set_reg(input int rd, input word_t v);
        if (rd != 0)
            xr[rd] = v;                           // x0 stays zero
    endtask

    // lw rd, imm(x0), value comes in on dmem_rdata_i
    task automatic load_reg(input int rd, input word_t value);
        logic [11:0] imm;
        imm = 12'($urandom) & 12'hffc;
        add_row($sformatf("lw x%0d", rd), {imm, 5'd0, 3'b010, 5'(rd), LOAD}, value,
                mpc + 4, 1'b1, 1'b0, sext12(imm), '0, 1'b0);
        set_reg(rd, value);
    endtask

    // sw rs2, imm(rs1), shows a register on dmem_wdata_o
    task automatic store_reg(input string name, input int rs2, input int rs1);
        logic [11:0] imm;
        imm = 12'($urandom);
        add_row(name, {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], STORE}, '0,
                mpc + 4, 1'b1, 1'b1, xr[rs1] + sext12(imm), xr[rs2], 1'b0);
    endtask

    task automatic r_type(input string mn, input logic [6:0] f7, input logic [2:0] f3);
        add_row(mn, {f7, 5'd2, 5'd1, f3, 5'd3, OP}, '0, mpc + 4, 1'b0, 1'b0, '0, '0, 1'b0);
        set_reg(3, alu_rule(mn, xr[1], xr[2]));  // x3 = x1 op x2
        store_reg({mn, " result"}, 3, 1);
    endtask

    task automatic i_type(input string mn, input logic [2:0] f3, input logic [11:0] imm);
        add_row(mn, {imm, 5'd1, f3, 5'd4, OP_IMM}, '0, mpc + 4, 1'b0, 1'b0, '0, '0, 1'b0);
        set_reg(4, alu_rule(mn, xr[1], sext12(imm)));
        store_reg({mn, " result"}, 4, 2);
    endtask

    task automatic branch_row(input string mn, input logic [2:0] f3, input int rs1, input int rs2);
        logic [12:0] imm;
        word_t       off;
        logic        taken;
        imm   = 13'($urandom) & 13'h1ffc;         // word-aligned offset
        off   = {{19{imm[12]}}, imm};
        taken = branch_taken(mn, xr[rs1], xr[rs2]);
        add_row($sformatf("%s x%0d x%0d %s", mn, rs1, rs2, taken ? "taken" : "not taken"),
                {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], BRANCH}, '0,
                taken ? mpc + off : mpc + 4, 1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    // no write, no request, pc moves on by 4
    task automatic illegal_row(input string name, input word_t instr);
        add_row(name, instr, '0, mpc + 4, 1'b0, 1'b0, '0, '0, 1'b1);
    endtask

    task automatic build_table();
        string       bname [6];
        logic [2:0]  bf3 [6];
        logic [19:0] imm20;
        logic [20:0] imm21;
        logic [11:0] imm12;
        word_t       tgt;
        xr    = '{default: '0};
        mpc   = RESET_PC;
        bname = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
        bf3   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        load_reg(1, rand_operand());
        load_reg(2, rand_operand());
        r_type("add", 7'h00, 3'b000);
        r_type("sub", 7'h20, 3'b000);
        r_type("sll", 7'h00, 3'b001);
        r_type("slt", 7'h00, 3'b010);
        r_type("sltu", 7'h00, 3'b011);
        r_type("xor", 7'h00, 3'b100);
        r_type("srl", 7'h00, 3'b101);
        r_type("sra", 7'h20, 3'b101);
        r_type("or", 7'h00, 3'b110);
        r_type("and", 7'h00, 3'b111);
        i_type("addi", 3'b000, 12'($urandom));
        i_type("slti", 3'b010, 12'($urandom));
        i_type("sltiu", 3'b011, 12'($urandom));
        i_type("xori", 3'b100, 12'($urandom));
        i_type("ori", 3'b110, 12'($urandom));
        i_type("andi", 3'b111, 12'($urandom));
        i_type("slli", 3'b001, {7'h00, 5'($urandom)});
        i_type("srli", 3'b101, {7'h00, 5'($urandom)});
        i_type("srai", 3'b101, {7'h20, 5'($urandom)});
        // upper immediates
        imm20 = 20'($urandom);
        set_reg(8, {imm20, 12'b0});
        add_row("lui", {imm20, 5'd8, LUI}, '0, mpc + 4, 1'b0, 1'b0, '0, '0, 1'b0);
        store_reg("lui result", 8, 0);
        imm20 = 20'($urandom);
        set_reg(9, mpc + {imm20, 12'b0});         // pc of the auipc itself
        add_row("auipc", {imm20, 5'd9, AUIPC}, '0, mpc + 4, 1'b0, 1'b0, '0, '0, 1'b0);
        store_reg("auipc result", 9, 0);
        for (int b = 0; b < 6; b++) begin         // each pair gives both outcomes
            branch_row(bname[b], bf3[b], 1, 2);
            branch_row(bname[b], bf3[b], 2, 1);
            branch_row(bname[b], bf3[b], 1, 1);
        end
        // jumps, link observed by sw
        imm21 = 21'($urandom) & 21'h1ffffc;
        set_reg(5, mpc + 4);
        add_row("jal", {imm21[20], imm21[10:1], imm21[11], imm21[19:12], 5'd5, JAL}, '0,
                mpc + {{11{imm21[20]}}, imm21}, 1'b0, 1'b0, '0, '0, 1'b0);
        store_reg("jal link", 5, 0);
        load_reg(7, rand_jalr_base());
        imm12 = 12'($urandom) & 12'hffc;
        tgt   = (xr[7] + sext12(imm12)) & ~32'h1;
        set_reg(6, mpc + 4);
        add_row("jalr", {imm12, 5'd7, 3'b000, 5'd6, JALR}, '0, tgt,
                1'b0, 1'b0, '0, '0, 1'b0);
        store_reg("jalr link", 6, 0);
        // fence / ecall / ebreak act as nop
        add_row("fence", 32'h0ff0_000f, '0, mpc + 4, 1'b0, 1'b0, '0, '0, 1'b0);
        add_row("ecall", 32'h0000_0073, '0, mpc + 4, 1'b0, 1'b0, '0, '0, 1'b0);
        add_row("ebreak", 32'h0010_0073, '0, mpc + 4, 1'b0, 1'b0, '0, '0, 1'b0);
        // illegal words all aim at x10, which must keep its value
        load_reg(10, rand_operand());
        illegal_row("bad opcode", {12'h005, 5'd1, 3'b000, 5'd10, 7'b0001011});
        illegal_row("low bits 00", {12'h005, 5'd1, 3'b000, 5'd10, 7'b0010000});
        illegal_row("sb", {7'h00, 5'd2, 5'd1, 3'b000, 5'd4, STORE});
        illegal_row("lb", {12'h000, 5'd0, 3'b000, 5'd10, LOAD});
        illegal_row("add funct7 01", {7'h01, 5'd2, 5'd1, 3'b000, 5'd10, OP});
        illegal_row("slli funct7 20", {7'h20, 5'd3, 5'd1, 3'b001, 5'd10, OP_IMM});
        illegal_row("branch funct3 010", {7'h00, 5'd2, 5'd1, 3'b010, 5'd0, BRANCH});
        store_reg("x10 kept", 10, 0);
    endtask

    // wait at falling edges until the fetch address shows pc
    task automatic wait_pc(input string name, input word_t pc, output bit reached);
        int cycles;
        cycles = 0;
        while (imem_addr !== pc && cycles < PC_WAIT) begin
            @(negedge CLK);
            cycles++;
        end
        reached = (imem_addr === pc);
        if (!reached) begin
            $display("%s: fetch address never reached %h within %0d cycles",
                     name, pc, PC_WAIT);
            row_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        RESET      = 1'b1;
        imem_data  = NOP;
        dmem_rdata = '0;
        void'($urandom(SEED));                    // the only seeding
        build_table();
        // a store and an all-zero word must stay quiet under reset
        reset_words = '{NOP, {7'h00, 5'd0, 5'd0, 3'b010, 5'd0, STORE}, 32'h0000_0000};
        foreach (reset_words[k]) begin            // 4th reset edge comes with row 0
            @(posedge CLK);
            imem_data <= reset_words[k];
            @(negedge CLK);
            check_flag("reset", "dmem_req_o", 1'b0, dmem_req);
            check_flag("reset", "dmem_we_o", 1'b0, dmem_we);
            check_flag("reset", "illegal_instr_o", 1'b0, illegal);
        end
        wait_pc("reset", RESET_PC, pc_ok);
        if (pc_ok) begin
            foreach (rows[i]) begin
                @(posedge CLK);
                if (i == 0)
                    RESET <= 1'b0;
                imem_data  <= rows[i].instr;
                dmem_rdata <= rows[i].rdata;
                @(negedge CLK);
                // fetch address after the edge closes the previous test
                check_word(i == 0 ? "reset" : rows[i-1].name, "imem_addr_o",
                           i == 0 ? RESET_PC : rows[i-1].next_pc, imem_addr);
                test_done(i == 0 ? "reset" : rows[i-1].name);
                check_flag(rows[i].name, "illegal_instr_o", rows[i].ill, illegal);
                check_flag(rows[i].name, "dmem_req_o", rows[i].req, dmem_req);
                if (rows[i].req) begin
                    check_flag(rows[i].name, "dmem_we_o", rows[i].we, dmem_we);
                    check_word(rows[i].name, "dmem_addr_o", rows[i].addr, dmem_addr);
                end
                if (rows[i].we)
                    check_word(rows[i].name, "dmem_wdata_o", rows[i].wdata, dmem_wdata);
            end
            @(posedge CLK);
            imem_data <= NOP;
            @(negedge CLK);
            check_word(rows[$].name, "imem_addr_o", rows[$].next_pc, imem_addr);
            test_done(rows[$].name);
        end else begin
            test_done("reset");
        end
        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hw/riscv_pkg.sv
hw/riscv_ctrl_if.sv
hw/riscv_decoder.sv
hw/riscv_operand_sel.sv
hw/riscv_alu.sv
hw/riscv_regfile.sv
hw/riscv_fetch.sv
hw/riscv_core.sv
test/riscv_core_tb.sv
